/* src.f */
design/dma_pkg.sv
design/dma_ifs.sv
design/dma_frontend_regs.sv
design/dma_frontend.sv
design/dma_copy_backend.sv
design/dma_scratch_mem.sv
design/dma_top.sv
bench/dma_properties.sv
bench/dma_checker.sv
bench/dma_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then search the log for the fail line
rm -f sim.log
verilator --binary --assert --top-module dma_tb -f src.f -o dma_sim \
  && ./obj_dir/dma_sim > sim.log 2>&1 \
  || echo "Result: FAILED" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0

/* bench/dma_tb.sv */
/*
  dma_top testbench with seeded random copies against a word model of the memory
  the host port is used only while STATUS shows the backend idle
*/
`timescale 1ns/1ps

module dma_tb;

  localparam int unsigned mem_addr_width = 8;
  localparam int unsigned mem_words      = 2**mem_addr_width;
  localparam int unsigned n_random       = 20;
  // random copies, three in the stall test and one zero length burst
  localparam int unsigned n_programs     = n_random + 4;
  localparam int unsigned max_words      = 16;
  localparam int unsigned limit_cycles   = n_programs * (2 * max_words + 50) + 200;
  localparam logic [31:0] addr_mask      = (mem_words - 1) << 2;

  logic                      clk;
  logic                      arst_n;
  logic                      reg_valid;
  logic                      reg_write;
  logic [3:0]                reg_addr;
  logic [31:0]               reg_wdata;
  logic                      reg_ready;
  logic [31:0]               reg_rdata;
  logic                      mem_req;
  logic                      mem_we;
  logic [mem_addr_width-1:0] mem_addr;
  logic [31:0]               mem_wdata;
  logic [31:0]               mem_rdata;
  logic                      chk_reg;
  logic [31:0]               exp_reg;
  logic                      chk_mem;
  logic [31:0]               exp_mem;
  int                        checker_errors;
  logic [31:0]               model [mem_words];
  integer                    seed;

  dma_top #(.mem_addr_width(mem_addr_width)) UUT (
    .clk_i(clk), .arst_n_i(arst_n),
    .reg_valid_i(reg_valid), .reg_write_i(reg_write), .reg_addr_i(reg_addr),
    .reg_wdata_i(reg_wdata), .reg_ready_o(reg_ready), .reg_rdata_o(reg_rdata),
    .mem_req_i(mem_req), .mem_we_i(mem_we), .mem_addr_i(mem_addr),
    .mem_wdata_i(mem_wdata), .mem_rdata_o(mem_rdata)
  );

  dma_checker u_checker (
    .clk_i(clk), .reg_valid_i(reg_valid), .reg_write_i(reg_write), .reg_ready_i(reg_ready),
    .reg_rdata_i(reg_rdata), .mem_req_i(mem_req), .mem_we_i(mem_we), .mem_rdata_i(mem_rdata),
    .chk_reg_i(chk_reg), .exp_reg_i(exp_reg), .chk_mem_i(chk_mem), .exp_mem_i(exp_mem),
    .errors_o(checker_errors)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // one register access, held until ready, data sampled mid cycle
  task automatic reg_access(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
                            input logic check, input logic [31:0] expected,
                            output logic [31:0] rdata);
    reg_valid = 1'b1;
    reg_write = write;
    reg_addr  = addr;
    reg_wdata = wdata;
    chk_reg   = check;
    exp_reg   = expected;
    @(negedge clk);
    while (!reg_ready) @(negedge clk);
    rdata = reg_rdata;
    @(posedge clk);
    #1;
    reg_valid = 1'b0;
    chk_reg   = 1'b0;
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    reg_access(1'b1, addr, data, 1'b0, 32'd0, unused);
  endtask

  task automatic check_reg(input logic [3:0] addr, input logic [31:0] expected);
    logic [31:0] unused;
    reg_access(1'b0, addr, 32'd0, 1'b1, expected, unused);
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
    reg_access(1'b0, addr, 32'd0, 1'b0, 32'd0, data);
  endtask

  task automatic host_write(input int unsigned addr, input logic [31:0] data);
    mem_req   = 1'b1;
    mem_we    = 1'b1;
    mem_addr  = addr[mem_addr_width-1:0];
    mem_wdata = data;
    @(posedge clk);
    #1;
    mem_req = 1'b0;
  endtask

  // read one word, the checker compares it with the model a cycle later
  task automatic host_check(input int unsigned addr);
    mem_req  = 1'b1;
    mem_we   = 1'b0;
    mem_addr = addr[mem_addr_width-1:0];
    chk_mem  = 1'b1;
    exp_mem  = model[addr];
    @(posedge clk);
    #1;
    mem_req = 1'b0;
    chk_mem = 1'b0;
  endtask

  // program with random unused address bits, launch, and apply to the model
  task automatic launch_copy(input int unsigned src_w, input int unsigned dst_w,
                             input int unsigned words);
    logic [31:0] r;
    r = $random(seed);
    write_reg(dma_pkg::reg_src, (r & ~addr_mask) | 32'(src_w << 2));
    r = $random(seed);
    write_reg(dma_pkg::reg_dst, (r & ~addr_mask) | 32'(dst_w << 2));
    r = $random(seed);
    write_reg(dma_pkg::reg_num_bytes, 32'(words << 2) | (r & 32'h3));
    check_reg(dma_pkg::reg_next_id, 32'd0);
    for (int unsigned i = 0; i < words; i++) begin
      model[(dst_w + i) % mem_words] = model[(src_w + i) % mem_words];
    end
  endtask

  // poll DONE, then either check STATUS or wait for it with queued bursts
  task automatic wait_done(input bit poll_status);
    logic [31:0] d;
    d = '0;
    while (!d[0]) read_reg(dma_pkg::reg_done, d);
    if (poll_status) begin
      d = '0;
      while (!d[0]) read_reg(dma_pkg::reg_status, d);
    end else begin
      check_reg(dma_pkg::reg_status, 32'd1);
    end
  endtask

  // random length, destination placed so the two ranges never overlap
  task automatic random_copy;
    int unsigned words;
    int unsigned src_w;
    int unsigned dst_w;
    words = $unsigned($random(seed)) % (max_words + 1);
    src_w = $unsigned($random(seed)) % mem_words;
    dst_w = (src_w + words + $unsigned($random(seed)) % (mem_words - 2 * words + 1)) % mem_words;
    launch_copy(src_w, dst_w, words);
    check_reg(dma_pkg::reg_done, 32'd0);
    wait_done(1'b0);
    for (int unsigned i = 0; i < words; i++) begin
      host_check((dst_w + i) % mem_words);
    end
  endtask

  task automatic finish_run(input bit timed_out);
    int assert_errors;
    assert_errors = UUT.i_frontend.u_props.fails_q;
    $display("errors: checker %0d, assertions %0d, timeout %0d",
             checker_errors, assert_errors, timed_out);
    if (timed_out || checker_errors != 0 || assert_errors != 0) begin
      $display("Result: FAILED");
    end else begin
      $display("Result: PASSED");
    end
    $finish;
  endtask

  initial begin
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: the DMA run did not finish within %0d cycles", limit_cycles);
    finish_run(1'b1);
  end

  initial begin
    logic [31:0] r;
    seed      = 32'h858128a0;
    arst_n    = 1'b0;
    reg_valid = 1'b0;
    reg_write = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    mem_req   = 1'b0;
    mem_we    = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    chk_reg   = 1'b0;
    exp_reg   = '0;
    chk_mem   = 1'b0;
    exp_mem   = '0;
    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;
    // reset values
    check_reg(dma_pkg::reg_src, 32'd0);
    check_reg(dma_pkg::reg_dst, 32'd0);
    check_reg(dma_pkg::reg_num_bytes, 32'd0);
    check_reg(dma_pkg::reg_done, 32'd0);
    check_reg(dma_pkg::reg_status, 32'd1);
    // readback, read-only and unused offsets
    for (int i = 0; i < 3; i++) begin
      r = $random(seed);
      write_reg(4'(i), r);
      check_reg(4'(i), r);
    end
    write_reg(dma_pkg::reg_status, $random(seed));
    write_reg(dma_pkg::reg_done, $random(seed));
    check_reg(dma_pkg::reg_status, 32'd1);
    check_reg(dma_pkg::reg_done, 32'd0);
    check_reg(4'd9, 32'd0);
    for (int unsigned i = 0; i < mem_words; i++) begin
      model[i] = $random(seed);
      host_write(i, model[i]);
    end
    repeat (n_random) random_copy();
    // long wrapping copy keeps the backend busy, the third launch stalls
    launch_copy(248, 100, max_words);
    launch_copy(120, 20, 5);
    launch_copy(20, 40, 5);
    wait_done(1'b1);
    // byte count below one word
    launch_copy(10, 200, 0);
    wait_done(1'b0);
    for (int unsigned i = 0; i < mem_words; i++) begin
      host_check(i);
    end
    repeat (2) @(posedge clk);
    finish_run(1'b0);
  end

endmodule

/* bench/dma_checker.sv */
/*
  compares register read data and host read data with the expected values
  host read data is checked one cycle after the accepted read
*/
`timescale 1ns/1ps

module dma_checker (
  input  logic                                 clk_i,
  input  logic                                 reg_valid_i,
  input  logic                                 reg_write_i,
  input  logic                                 reg_ready_i,
  input  logic [dma_pkg::data_width-1:0]       reg_rdata_i,
  input  logic                                 mem_req_i,
  input  logic                                 mem_we_i,
  input  logic [dma_pkg::data_width-1:0]       mem_rdata_i,
  input  logic                                 chk_reg_i,
  input  logic [dma_pkg::data_width-1:0]       exp_reg_i,
  input  logic                                 chk_mem_i,
  input  logic [dma_pkg::data_width-1:0]       exp_mem_i,
  output int                                   errors_o
);

  int                             errors_q = 0;
  logic                           mem_pending_q = 1'b0;
  logic [dma_pkg::data_width-1:0] mem_exp_q;

  always @(posedge clk_i) begin
    // register data is valid in the accepting cycle
    if (reg_valid_i && !reg_write_i && reg_ready_i && chk_reg_i) begin
      if (reg_rdata_i !== exp_reg_i) begin
        errors_q = errors_q + 1;
        $display("Error %0t reg_rdata_o expected %h got %h", $time, exp_reg_i, reg_rdata_i);
      end
    end
    // memory read data follows one cycle after the request
    if (mem_pending_q && (mem_rdata_i !== mem_exp_q)) begin
      errors_q = errors_q + 1;
      $display("Error %0t mem_rdata_o expected %h got %h", $time, mem_exp_q, mem_rdata_i);
    end
    mem_pending_q <= mem_req_i && !mem_we_i && chk_mem_i;
    mem_exp_q     <= exp_mem_i;
  end

  assign errors_o = errors_q;

endmodule

/* bench/dma_properties.sv */
/*
  frontend burst channel assertions, bound into dma_frontend
  checked only while arst_n_i is high
*/
`timescale 1ns/1ps

module dma_properties (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic                                 valid_i,
  input  logic                                 ready_i,
  input  logic                                 done_i,
  input  dma_pkg::burst_req_t                  req_i,
  input  logic                                 reg_valid_i,
  input  logic                                 reg_write_i,
  input  logic [dma_pkg::reg_addr_width-1:0]   reg_addr_i,
  input  logic                                 reg_ready_i
);

  // failed assertion count, read by the testbench at the end
  int   fails_q = 0;
  logic next_id_acc;

  // NEXT_ID read seen on the register bus and accepted there
  assign next_id_acc = reg_valid_i & ~reg_write_i & reg_ready_i
                       & (reg_addr_i == dma_pkg::reg_next_id);

  // a waiting burst keeps valid and its request until the backend takes it
  hold_until_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_i && !ready_i |=> valid_i && $stable(req_i))
    else begin
      fails_q = fails_q + 1;
      $error("burst valid dropped or request changed before ready");
    end

  // completion is a single cycle pulse
  done_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    done_i |=> !done_i)
    else begin
      fails_q = fails_q + 1;
      $error("done pulse held high for two cycles");
    end

  // burst valid rises only after an accepted NEXT_ID read on the bus
  valid_from_read: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(valid_i) |-> $past(next_id_acc))
    else begin
      fails_q = fails_q + 1;
      $error("burst valid raised without an accepted NEXT_ID read");
    end

  // every accepted NEXT_ID read hands a burst to the backend
  read_raises_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    next_id_acc |=> valid_i)
    else begin
      fails_q = fails_q + 1;
      $error("accepted NEXT_ID read did not raise burst valid");
    end

endmodule

bind dma_frontend dma_properties u_props (
  .clk_i      (clk_i),
  .arst_n_i   (arst_n_i),
  .valid_i    (valid_q),
  .ready_i    (burst.ready),
  .done_i     (burst.done),
  .req_i      (req_q),
  .reg_valid_i(reg_valid_i),
  .reg_write_i(reg_write_i),
  .reg_addr_i (reg_addr_i),
  .reg_ready_i(reg_ready_o)
);

/* design/dma_top.sv */
/*
  copy DMA top: register frontend, word copy backend and scratch memory
  use the host port only while STATUS reads idle
*/
`timescale 1ns/1ps

module dma_top #(
  parameter int unsigned mem_addr_width = 8
) (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  // register bus
  input  logic                                 reg_valid_i,
  input  logic                                 reg_write_i,
  input  logic [dma_pkg::reg_addr_width-1:0]   reg_addr_i,
  input  logic [dma_pkg::data_width-1:0]       reg_wdata_i,
  output logic                                 reg_ready_o,
  output logic [dma_pkg::data_width-1:0]       reg_rdata_o,
  // host memory port
  input  logic                                 mem_req_i,
  input  logic                                 mem_we_i,
  input  logic [mem_addr_width-1:0]            mem_addr_i,
  input  logic [dma_pkg::data_width-1:0]       mem_wdata_i,
  output logic [dma_pkg::data_width-1:0]       mem_rdata_o
);

  dma_burst_if burst_if ();
  dma_mem_if #(.mem_addr_width(mem_addr_width)) mem_if ();

  dma_frontend i_frontend (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .reg_valid_i(reg_valid_i),
    .reg_write_i(reg_write_i),
    .reg_addr_i (reg_addr_i),
    .reg_wdata_i(reg_wdata_i),
    .reg_ready_o(reg_ready_o),
    .reg_rdata_o(reg_rdata_o),
    .burst      (burst_if.frontend)
  );

  dma_copy_backend #(.mem_addr_width(mem_addr_width)) i_backend (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .burst   (burst_if.backend),
    .mem     (mem_if.master)
  );

  // backend owns the memory whenever it is not idle
  dma_scratch_mem #(.mem_addr_width(mem_addr_width)) i_mem (
    .clk_i         (clk_i),
    .backend_busy_i(~burst_if.idle),
    .host_req_i    (mem_req_i),
    .host_we_i     (mem_we_i),
    .host_addr_i   (mem_addr_i),
    .host_wdata_i  (mem_wdata_i),
    .host_rdata_o  (mem_rdata_o),
    .mem           (mem_if.slave)
  );

endmodule

/* design/dma_scratch_mem.sv */
/*
  single port scratch memory shared by the backend and the host
  the host is served only while the backend is idle, its requests are dropped otherwise
*/
`timescale 1ns/1ps

module dma_scratch_mem #(
  parameter int unsigned mem_addr_width = 8
) (
  input  logic                                clk_i,
  input  logic                                backend_busy_i,
  input  logic                                host_req_i,
  input  logic                                host_we_i,
  input  logic [mem_addr_width-1:0]           host_addr_i,
  input  logic [dma_pkg::data_width-1:0]      host_wdata_i,
  output logic [dma_pkg::data_width-1:0]      host_rdata_o,
  dma_mem_if.slave                            mem
);

  logic [dma_pkg::data_width-1:0] ram_q [2**mem_addr_width];
  logic [dma_pkg::data_width-1:0] rdata_q;
  logic                           req;
  logic                           we;
  logic [mem_addr_width-1:0]      addr;
  logic [dma_pkg::data_width-1:0] wdata;

  // port select follows the backend busy state
  assign req   = backend_busy_i ? mem.req   : host_req_i;
  assign we    = backend_busy_i ? mem.we    : host_we_i;
  assign addr  = backend_busy_i ? mem.addr  : host_addr_i;
  assign wdata = backend_busy_i ? mem.wdata : host_wdata_i;

  // read data is held until the next read
  always_ff @(posedge clk_i) begin
    if (req) begin
      if (we) begin
        ram_q[addr] <= wdata;
      end else begin
        rdata_q <= ram_q[addr];
      end
    end
  end

  // one read register, both sides see it
  assign mem.rdata    = rdata_q;
  assign host_rdata_o = rdata_q;

endmodule

/* design/dma_copy_backend.sv */
/*
  word copy backend, one read cycle then one write cycle per word
  word pointers wrap at the memory size, a zero word count only pulses done
*/
`timescale 1ns/1ps

module dma_copy_backend #(
  parameter int unsigned mem_addr_width = 8
) (
  input  logic          clk_i,
  input  logic          arst_n_i,
  dma_burst_if.backend  burst,
  dma_mem_if.master     mem
);

  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_read  = 2'd1;
  localparam logic [1:0] st_write = 2'd2;

  logic [1:0]                     state_q;
  logic [dma_pkg::data_width-3:0] words_q;
  logic [dma_pkg::data_width-3:0] req_words;
  logic [mem_addr_width-1:0]      src_ptr_q;
  logic [mem_addr_width-1:0]      dst_ptr_q;
  logic                           done_q;
  logic                           accept;

  // byte count down to whole words
  assign req_words = burst.req.num_bytes[dma_pkg::data_width-1:2];
  assign accept    = burst.valid & (state_q == st_idle);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= st_idle;
      words_q <= '0;
      done_q  <= 1'b0;
    end else begin
      // done is a single cycle pulse
      done_q <= 1'b0;
      case (state_q)
        st_idle: begin
          if (accept) begin
            if (req_words == '0) begin
              // nothing to move, complete right away
              done_q <= 1'b1;
            end else begin
              words_q <= req_words;
              state_q <= st_read;
            end
          end
        end
        st_read: begin
          state_q <= st_write;
        end
        st_write: begin
          words_q <= words_q - 1'b1;
          if (words_q == 1) begin
            // last word written, back to idle with the done pulse
            state_q <= st_idle;
            done_q  <= 1'b1;
          end else begin
            state_q <= st_read;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // word pointers from address bits above the byte offset
  always_ff @(posedge clk_i) begin
    if (accept) begin
      src_ptr_q <= burst.req.src[mem_addr_width+1:2];
      dst_ptr_q <= burst.req.dst[mem_addr_width+1:2];
    end else if (state_q == st_write) begin
      src_ptr_q <= src_ptr_q + 1'b1;
      dst_ptr_q <= dst_ptr_q + 1'b1;
    end
  end

  // read data of the previous cycle goes straight back out
  assign mem.req   = (state_q != st_idle);
  assign mem.we    = (state_q == st_write);
  assign mem.addr  = (state_q == st_write) ? dst_ptr_q : src_ptr_q;
  assign mem.wdata = mem.rdata;

  assign burst.ready = (state_q == st_idle);
  assign burst.idle  = (state_q == st_idle);
  assign burst.done  = done_q;

endmodule

/* design/dma_frontend.sv */
/*
  DMA frontend: holds one launched burst until the backend takes it
  a second NEXT_ID read stalls the register bus while a burst is pending
  DONE is sticky, set by the backend pulse and cleared by the next launch
*/
`timescale 1ns/1ps

module dma_frontend (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic                                 reg_valid_i,
  input  logic                                 reg_write_i,
  input  logic [dma_pkg::reg_addr_width-1:0]   reg_addr_i,
  input  logic [dma_pkg::data_width-1:0]       reg_wdata_i,
  output logic                                 reg_ready_o,
  output logic [dma_pkg::data_width-1:0]       reg_rdata_o,
  dma_burst_if.frontend                        burst
);

  logic                launch;
  dma_pkg::burst_req_t prog;
  logic                valid_q;
  dma_pkg::burst_req_t req_q;
  logic                done_q;

  dma_frontend_regs i_regs (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .reg_valid_i   (reg_valid_i),
    .reg_write_i   (reg_write_i),
    .reg_addr_i    (reg_addr_i),
    .reg_wdata_i   (reg_wdata_i),
    .backend_idle_i(burst.idle),
    .done_i        (done_q),
    // pending burst blocks the next launch
    .stall_i       (valid_q),
    .reg_ready_o   (reg_ready_o),
    .reg_rdata_o   (reg_rdata_o),
    .launch_o      (launch),
    .burst_o       (prog)
  );

  // launch raises valid, the handshake drops it
  // launch cannot coincide with a pending burst because of the stall
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (launch) begin
      valid_q <= 1'b1;
    end else if (valid_q && burst.ready) begin
      valid_q <= 1'b0;
    end
  end

  // snapshot so later register writes leave the pending burst alone
  always_ff @(posedge clk_i) begin
    if (launch) begin
      req_q <= prog;
    end
  end

  // launch wins over a completion in the same cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_q <= 1'b0;
    end else if (launch) begin
      done_q <= 1'b0;
    end else if (burst.done) begin
      done_q <= 1'b1;
    end
  end

  assign burst.valid = valid_q;
  assign burst.req   = req_q;

endmodule

/* design/dma_frontend_regs.sv */
/*
  register file of the DMA frontend on a request/ready register bus
  read data is combinational and valid in the accepting cycle
  only a NEXT_ID read can be held off, by stall_i
*/
`timescale 1ns/1ps

module dma_frontend_regs (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic                                 reg_valid_i,
  input  logic                                 reg_write_i,
  input  logic [dma_pkg::reg_addr_width-1:0]   reg_addr_i,
  input  logic [dma_pkg::data_width-1:0]       reg_wdata_i,
  input  logic                                 backend_idle_i,
  input  logic                                 done_i,
  input  logic                                 stall_i,
  output logic                                 reg_ready_o,
  output logic [dma_pkg::data_width-1:0]       reg_rdata_o,
  output logic                                 launch_o,
  output dma_pkg::burst_req_t                  burst_o
);

  logic [dma_pkg::data_width-1:0] src_q;
  logic [dma_pkg::data_width-1:0] dst_q;
  logic [dma_pkg::data_width-1:0] num_bytes_q;
  logic                           wr_en;
  logic                           next_id_rd;

  // writes are never stalled
  assign wr_en      = reg_valid_i & reg_write_i;
  // read of the launch register, before the stall is applied
  assign next_id_rd = reg_valid_i & ~reg_write_i & (reg_addr_i == dma_pkg::reg_next_id);

  // hold the master off while the previous burst is still waiting
  assign reg_ready_o = ~(next_id_rd & stall_i);
  // single cycle strobe, only when the read is actually accepted
  assign launch_o    = next_id_rd & ~stall_i;

  // programmable registers, read-only offsets drop the write
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_q       <= '0;
      dst_q       <= '0;
      num_bytes_q <= '0;
    end else if (wr_en) begin
      case (reg_addr_i)
        dma_pkg::reg_src:       src_q       <= reg_wdata_i;
        dma_pkg::reg_dst:       dst_q       <= reg_wdata_i;
        dma_pkg::reg_num_bytes: num_bytes_q <= reg_wdata_i;
        default: ;
      endcase
    end
  end

  // read mux, unused offsets and NEXT_ID return zero
  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      dma_pkg::reg_src:       reg_rdata_o = src_q;
      dma_pkg::reg_dst:       reg_rdata_o = dst_q;
      dma_pkg::reg_num_bytes: reg_rdata_o = num_bytes_q;
      dma_pkg::reg_status:    reg_rdata_o[0] = backend_idle_i;
      dma_pkg::reg_done:      reg_rdata_o[0] = done_i;
      default:                reg_rdata_o = '0;
    endcase
  end

  // current program, the frontend snapshots it on launch
  assign burst_o.src       = src_q;
  assign burst_o.dst       = dst_q;
  assign burst_o.num_bytes = num_bytes_q;

endmodule

/* design/dma_ifs.sv */
/*
  burst channel between frontend and backend, and the scratch memory port
  memory read data arrives one cycle after the read request
*/
`timescale 1ns/1ps

// valid/ready burst channel plus backend status
interface dma_burst_if;
  logic                valid;
  dma_pkg::burst_req_t req;
  logic                ready;
  // backend has no copy in flight
  logic                idle;
  // one cycle completion pulse
  logic                done;

  modport frontend (output valid, req, input ready, idle, done);
  modport backend  (input valid, req, output ready, idle, done);
endinterface

// single port word memory access
interface dma_mem_if #(
  parameter int unsigned mem_addr_width = 8
);
  logic                            req;
  logic                            we;
  logic [mem_addr_width-1:0]       addr;
  logic [dma_pkg::data_width-1:0]  wdata;
  logic [dma_pkg::data_width-1:0]  rdata;

  modport master (output req, we, addr, wdata, input rdata);
  modport slave  (input req, we, addr, wdata, output rdata);
endinterface

/* design/dma_pkg.sv */
/*
  shared widths, register map and burst request type of the copy DMA
  all addresses and byte counts are word aligned, the low two bits are ignored
*/
package dma_pkg;

  // register bus word address and data width
  localparam int unsigned reg_addr_width = 4;
  localparam int unsigned data_width     = 32;

  // register map, word offsets
  localparam logic [reg_addr_width-1:0] reg_src       = 4'd0;
  localparam logic [reg_addr_width-1:0] reg_dst       = 4'd1;
  localparam logic [reg_addr_width-1:0] reg_num_bytes = 4'd2;
  // bit 0 set while the backend is idle
  localparam logic [reg_addr_width-1:0] reg_status    = 4'd3;
  // reading this one launches a burst, always returns zero
  localparam logic [reg_addr_width-1:0] reg_next_id   = 4'd4;
  // bit 0 is the sticky completion flag
  localparam logic [reg_addr_width-1:0] reg_done      = 4'd5;

  // one dimensional copy request handed to the backend
  typedef struct packed {
    logic [data_width-1:0] src;
    logic [data_width-1:0] dst;
    logic [data_width-1:0] num_bytes;
  } burst_req_t;

endpackage
